// File: include/ooo_params.svh
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// datapath width
`define XLEN 32

// number of identical integer ALU lanes
`define NUM_LANES 4

// reorder buffer size, tag indexes it directly
`define ROB_DEPTH 16
`define TAG_W 4

// instruction queue in front of dispatch
`define IQ_DEPTH 8

// credits per lane, equal to the lane queue depth
`define LANE_DEPTH 2

`define ORDER_W 64

`endif

// File: verilog/ooo_pkg.sv
`include "ooo_params.svh"

package ooo_pkg;

    // integer ALU operations, RV32I semantics
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

    // decoded operation as it enters the back end
    typedef struct packed {
        alu_op_e           op;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
    } inst_t;

    // operation carrying its reorder buffer slot
    typedef struct packed {
        inst_t             inst;
        logic [`TAG_W-1:0] tag;
    } tagged_inst_t;

endpackage

// File: verilog/lane_if.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

interface lane_if;

    // issue side, dispatcher to lane
    logic                   issue_valid;
    ooo_pkg::tagged_inst_t  issue_op;
    logic                   credit;

    // writeback side, lane to reorder buffer
    logic                   result_valid;
    logic [`TAG_W-1:0]      result_tag;
    logic [`XLEN-1:0]       result_data;

    modport dispatch (output issue_valid, output issue_op, input credit);

    modport lane (
        input  issue_valid,
        input  issue_op,
        output credit,
        output result_valid,
        output result_tag,
        output result_data
    );

    modport rob (input result_valid, input result_tag, input result_data);

endinterface

// File: verilog/op_queue.sv
`timescale 1ns/1ps

module op_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at DEPTH so non power of two depths work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // head is always visible
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/dispatch_unit.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module dispatch_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::inst_t       head_i,
    input  logic                 empty_i,
    output logic                 pop_o,
    input  logic                 alloc_ready_i,
    input  logic [`TAG_W-1:0]    alloc_tag_i,
    output logic                 alloc_valid_o,
    output logic [4:0]           alloc_rd_o,
    lane_if.dispatch             lanes [`NUM_LANES]
);

    localparam int LANE_W = $clog2(`NUM_LANES);
    localparam int CRED_W = $clog2(`LANE_DEPTH + 1);

    logic [CRED_W-1:0]     credits [`NUM_LANES];
    logic [`NUM_LANES-1:0] has_credit;
    logic [`NUM_LANES-1:0] credit_in;
    logic [`NUM_LANES-1:0] issue_valid;
    logic [LANE_W-1:0]     rr_ptr;
    logic [LANE_W-1:0]     sel_lane;
    logic                  sel_found;
    logic                  fire;
    ooo_pkg::tagged_inst_t issue_op;

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        assign has_credit[g]        = (credits[g] != '0);
        assign credit_in[g]         = lanes[g].credit;
        assign lanes[g].issue_valid = issue_valid[g];
        assign lanes[g].issue_op    = issue_op;
    end

    // first lane with credit, starting at the round-robin pointer
    always_comb begin
        int unsigned cand;
        sel_found = 1'b0;
        sel_lane  = '0;
        for (int k = 0; k < `NUM_LANES; k++) begin
            cand = (int'(rr_ptr) + k) % `NUM_LANES;
            if (!sel_found && has_credit[cand]) begin
                sel_found = 1'b1;
                sel_lane  = LANE_W'(cand);
            end
        end
    end

    // dequeue, allocate and issue in one cycle
    assign fire          = !empty_i && alloc_ready_i && sel_found;
    assign pop_o         = fire;
    assign alloc_valid_o = fire;
    assign alloc_rd_o    = head_i.rd;
    assign issue_op      = '{inst: head_i, tag: alloc_tag_i};

    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            issue_valid[i] = fire && (sel_lane == LANE_W'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
            for (int i = 0; i < `NUM_LANES; i++) begin
                credits[i] <= CRED_W'(`LANE_DEPTH);
            end
        end else begin
            if (fire) begin
                rr_ptr <= LANE_W'((int'(sel_lane) + 1) % `NUM_LANES);
            end
            // a lane can take an issue and return a credit in the same cycle
            for (int i = 0; i < `NUM_LANES; i++) begin
                case ({issue_valid[i], credit_in[i]})
                    2'b10:   credits[i] <= credits[i] - 1'b1;
                    2'b01:   credits[i] <= credits[i] + 1'b1;
                    default: credits[i] <= credits[i];
                endcase
            end
        end
    end

endmodule

// File: verilog/alu_lane.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module alu_lane (
    input  logic clk,
    input  logic rst,
    lane_if.lane port
);

    ooo_pkg::tagged_inst_t head;
    logic                  q_empty;
    logic                  pop;
    logic [`XLEN-1:0]      opa;
    logic [`XLEN-1:0]      opb;
    logic [4:0]            shamt;
    logic [`XLEN-1:0]      alu_result;
    logic                  res_valid;
    logic [`TAG_W-1:0]     res_tag;
    logic [`XLEN-1:0]      res_data;

    // credit flow keeps this queue from overflowing
    op_queue #(
        .payload_t (ooo_pkg::tagged_inst_t),
        .DEPTH     (`LANE_DEPTH)
    ) lane_q (
        .clk     (clk),
        .rst     (rst),
        .push_i  (port.issue_valid),
        .data_i  (port.issue_op),
        .pop_i   (pop),
        .data_o  (head),
        .empty_o (q_empty),
        .full_o  ()
    );

    // result reg drains into the ROB every cycle, so it is always free by the edge
    assign pop         = !q_empty;
    assign port.credit = pop;

    assign opa   = head.inst.a;
    assign opb   = head.inst.b;
    assign shamt = opb[4:0];

    always_comb begin
        case (head.inst.op)
            ooo_pkg::alu_add:  alu_result = opa + opb;
            ooo_pkg::alu_sub:  alu_result = opa - opb;
            ooo_pkg::alu_and:  alu_result = opa & opb;
            ooo_pkg::alu_or:   alu_result = opa | opb;
            ooo_pkg::alu_xor:  alu_result = opa ^ opb;
            ooo_pkg::alu_slt:  alu_result = {{(`XLEN-1){1'b0}}, ($signed(opa) < $signed(opb))};
            ooo_pkg::alu_sltu: alu_result = {{(`XLEN-1){1'b0}}, (opa < opb)};
            ooo_pkg::alu_sll:  alu_result = opa << shamt;
            ooo_pkg::alu_srl:  alu_result = opa >> shamt;
            ooo_pkg::alu_sra:  alu_result = $signed(opa) >>> shamt;
            default:           alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= pop;
        end
    end

    // tag and value, one cycle after the dequeue
    always_ff @(posedge clk) begin
        if (pop) begin
            res_tag  <= head.tag;
            res_data <= alu_result;
        end
    end

    assign port.result_valid = res_valid;
    assign port.result_tag   = res_tag;
    assign port.result_data  = res_data;

endmodule

// File: verilog/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_valid_i,
    input  logic [4:0]            alloc_rd_i,
    output logic                  alloc_ready_o,
    output logic [`TAG_W-1:0]     alloc_tag_o,
    lane_if.rob                   lanes [`NUM_LANES],
    input  logic                  commit_ready_i,
    output logic                  commit_valid_o,
    output logic [4:0]            commit_rd_o,
    output logic [`XLEN-1:0]      commit_data_o,
    output logic [`ORDER_W-1:0]   commit_order_o
);

    // entry table
    logic [4:0]             rd_tab   [`ROB_DEPTH];
    logic [`XLEN-1:0]       data_tab [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]  done_tab;

    logic [`TAG_W-1:0]      head;
    logic [`TAG_W-1:0]      tail;
    logic [`TAG_W:0]        count;
    logic [`ORDER_W-1:0]    order_cnt;
    logic                   alloc_fire;
    logic                   commit_fire;

    // writeback from every lane
    logic [`NUM_LANES-1:0]  wb_valid;
    logic [`TAG_W-1:0]      wb_tag  [`NUM_LANES];
    logic [`XLEN-1:0]       wb_data [`NUM_LANES];

    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_wb
        assign wb_valid[l] = lanes[l].result_valid;
        assign wb_tag[l]   = lanes[l].result_tag;
        assign wb_data[l]  = lanes[l].result_data;
    end

    assign alloc_ready_o = (count != (`TAG_W + 1)'(`ROB_DEPTH));
    assign alloc_tag_o   = tail;
    assign alloc_fire    = alloc_valid_i && alloc_ready_o;

    // head commits once its result is in
    assign commit_valid_o = done_tab[head];
    assign commit_fire    = commit_valid_o && commit_ready_i;
    assign commit_rd_o    = rd_tab[head];
    // x0 always reads as zero
    assign commit_data_o  = (rd_tab[head] == 5'd0) ? '0 : data_tab[head];
    assign commit_order_o = order_cnt;

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rd_tab[tail] <= alloc_rd_i;
        end
        for (int l = 0; l < `NUM_LANES; l++) begin
            if (wb_valid[l]) begin
                data_tab[wb_tag[l]] <= wb_data[l];
            end
        end
    end

    // pointers wrap on their own since ROB_DEPTH is 2**TAG_W
    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            order_cnt <= '0;
            done_tab  <= '0;
        end else begin
            if (alloc_fire) begin
                tail <= tail + 1'b1;
            end
            if (commit_fire) begin
                head           <= head + 1'b1;
                order_cnt      <= order_cnt + 1'b1;
                done_tab[head] <= 1'b0;
            end
            // results land out of order, by tag
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (wb_valid[l]) begin
                    done_tab[wb_tag[l]] <= 1'b1;
                end
            end
            case ({alloc_fire, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_core (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  ooo_pkg::alu_op_e      in_op_i,
    input  logic [4:0]            in_rd_i,
    input  logic [`XLEN-1:0]      in_a_i,
    input  logic [`XLEN-1:0]      in_b_i,

    output logic                  commit_valid_o,
    input  logic                  commit_ready_i,
    output logic [4:0]            commit_rd_o,
    output logic [`XLEN-1:0]      commit_data_o,
    output logic [`ORDER_W-1:0]   commit_order_o
);

    ooo_pkg::inst_t     in_inst;
    ooo_pkg::inst_t     iq_head;
    logic               iq_empty;
    logic               iq_full;
    logic               iq_pop;
    logic               alloc_valid;
    logic [4:0]         alloc_rd;
    logic               alloc_ready;
    logic [`TAG_W-1:0]  alloc_tag;

    lane_if lane_bus [`NUM_LANES] ();

    assign in_inst    = '{op: in_op_i, rd: in_rd_i, a: in_a_i, b: in_b_i};
    assign in_ready_o = !iq_full;

    op_queue #(
        .payload_t (ooo_pkg::inst_t),
        .DEPTH     (`IQ_DEPTH)
    ) inst_queue (
        .clk     (clk),
        .rst     (rst),
        .push_i  (in_valid_i),
        .data_i  (in_inst),
        .pop_i   (iq_pop),
        .data_o  (iq_head),
        .empty_o (iq_empty),
        .full_o  (iq_full)
    );

    dispatch_unit dispatch0 (
        .clk           (clk),
        .rst           (rst),
        .head_i        (iq_head),
        .empty_i       (iq_empty),
        .pop_o         (iq_pop),
        .alloc_ready_i (alloc_ready),
        .alloc_tag_i   (alloc_tag),
        .alloc_valid_o (alloc_valid),
        .alloc_rd_o    (alloc_rd),
        .lanes         (lane_bus)
    );

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_alu
        alu_lane lane0 (
            .clk  (clk),
            .rst  (rst),
            .port (lane_bus[g])
        );
    end

    reorder_buffer rob0 (
        .clk            (clk),
        .rst            (rst),
        .alloc_valid_i  (alloc_valid),
        .alloc_rd_i     (alloc_rd),
        .alloc_ready_o  (alloc_ready),
        .alloc_tag_o    (alloc_tag),
        .lanes          (lane_bus),
        .commit_ready_i (commit_ready_i),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .commit_order_o (commit_order_o)
    );

endmodule

// File: bench/ooo_core_asserts.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module dispatch_asserts #(
    parameter int CRED_W = $clog2(`LANE_DEPTH + 1)
) (
    input logic                  clk,
    input logic                  rst,
    input logic [CRED_W-1:0]     credits [`NUM_LANES],
    input logic [`NUM_LANES-1:0] issue_valid
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_chk
        // a lane never returns more credits than it has slots
        credit_bound: assert property (@(posedge clk) disable iff (rst)
            credits[g] <= CRED_W'(`LANE_DEPTH))
        else begin
            $error("lane %0d credit counter above lane depth", g);
            fail_count++;
        end

        // issue needs a free slot in the lane queue
        issue_has_credit: assert property (@(posedge clk) disable iff (rst)
            issue_valid[g] |-> (credits[g] != '0))
        else begin
            $error("lane %0d issued with no credit left", g);
            fail_count++;
        end
    end

endmodule

bind dispatch_unit dispatch_asserts asserts0 (
    .clk         (clk),
    .rst         (rst),
    .credits     (credits),
    .issue_valid (issue_valid)
);

// File: bench/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_core_tb;

    localparam int TOTAL_OPS  = 10 + 60 + 30 + 6;
    localparam int OP_CYCLES  = 24;
    localparam int HOLD_CYCLES = 60;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  in_valid_i;
    logic                  in_ready_o;
    ooo_pkg::alu_op_e      in_op_i;
    logic [4:0]            in_rd_i;
    logic [`XLEN-1:0]      in_a_i;
    logic [`XLEN-1:0]      in_b_i;
    logic                  commit_valid_o;
    logic                  commit_ready_i;
    logic [4:0]            commit_rd_o;
    logic [`XLEN-1:0]      commit_data_o;
    logic [`ORDER_W-1:0]   commit_order_o;

    // ops still to send, and what must commit, in program order
    ooo_pkg::inst_t        pend [$];
    logic [4:0]            exp_rd [$];
    logic [`XLEN-1:0]      exp_data [$];
    logic [`ORDER_W-1:0]   next_order = '0;
    logic [31:0]           rng_state = 32'h7c3a;

    ooo_core dut0 (
        .clk            (clk),
        .rst            (rst),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .in_op_i        (in_op_i),
        .in_rd_i        (in_rd_i),
        .in_a_i         (in_a_i),
        .in_b_i         (in_b_i),
        .commit_valid_o (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .commit_order_o (commit_order_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // reference ALU, RV32I rules plus the x0 rule
    function automatic logic [`XLEN-1:0] model_result(input ooo_pkg::alu_op_e op,
            input logic [4:0] rd, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        logic [4:0]       sh;
        logic [`XLEN-1:0] r;
        sh = b[4:0];
        case (op)
            ooo_pkg::alu_add:  r = a + b;
            ooo_pkg::alu_sub:  r = a + ~b + 1;
            ooo_pkg::alu_and:  r = a & b;
            ooo_pkg::alu_or:   r = a | b;
            ooo_pkg::alu_xor:  r = a ^ b;
            // signs differ, so the negative one is smaller
            ooo_pkg::alu_slt:  r = (a[`XLEN-1] != b[`XLEN-1]) ? `XLEN'(a[`XLEN-1]) : `XLEN'(a < b);
            ooo_pkg::alu_sltu: r = `XLEN'(a < b);
            ooo_pkg::alu_sll:  r = a << sh;
            ooo_pkg::alu_srl:  r = a >> sh;
            ooo_pkg::alu_sra: begin
                r = a >> sh;
                if (a[`XLEN-1]) begin
                    r = r | ~({`XLEN{1'b1}} >> sh);
                end
            end
            default:           r = '0;
        endcase
        return (rd == 5'd0) ? '0 : r;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input string name, input logic [`XLEN-1:0] expected,
            input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s data: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] expected,
            input logic [4:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s rd: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_order(input string name, input logic [`ORDER_W-1:0] expected,
            input logic [`ORDER_W-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s order: expected %0d, actual %0d",
                name, expected, actual));
        end
    endtask

    task automatic queue_op(input ooo_pkg::alu_op_e op, input logic [4:0] rd,
            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        pend.push_back('{op: op, rd: rd, a: a, b: b});
        exp_rd.push_back(rd);
        exp_data.push_back(model_result(op, rd, a, b));
    endtask

    task automatic queue_random_ops(input int n);
        repeat (n) begin
            queue_op(ooo_pkg::alu_op_e'(4'(xorshift32() % 10)), 5'(xorshift32() % 31 + 1),
                xorshift32(), xorshift32());
        end
    endtask

    // entered and left on a falling edge
    task automatic send_pending();
        ooo_pkg::inst_t op;
        while (pend.size() > 0) begin
            op = pend.pop_front();
            in_valid_i = 1'b1;
            in_op_i    = op.op;
            in_rd_i    = op.rd;
            in_a_i     = op.a;
            in_b_i     = op.b;
            while (!in_ready_o) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        in_valid_i = 1'b0;
    endtask

    task automatic collect_commits(input string name, input int n);
        int got;
        got = 0;
        commit_ready_i = 1'b1;
        while (got < n) begin
            if (commit_valid_o) begin
                check_rd(name, exp_rd.pop_front(), commit_rd_o);
                check_data(name, exp_data.pop_front(), commit_data_o);
                check_order(name, next_order, commit_order_o);
                next_order = next_order + 1'b1;
                got++;
            end
            @(negedge clk);
        end
    endtask

    // commit stalled, head must hold still while the core fills up
    task automatic hold_commits(input string name, input int cycles);
        logic                held;
        logic                seen_full;
        logic [4:0]          hold_rd;
        logic [`XLEN-1:0]    hold_data;
        logic [`ORDER_W-1:0] hold_order;
        held = 1'b0;
        seen_full = 1'b0;
        commit_ready_i = 1'b0;
        repeat (cycles) begin
            if (!in_ready_o) begin
                seen_full = 1'b1;
            end
            if (held) begin
                if (!commit_valid_o) begin
                    abort_run("commit_valid_o dropped while commit_ready_i was low");
                end
                check_rd(name, hold_rd, commit_rd_o);
                check_data(name, hold_data, commit_data_o);
                check_order(name, hold_order, commit_order_o);
            end else if (commit_valid_o) begin
                held       = 1'b1;
                hold_rd    = commit_rd_o;
                hold_data  = commit_data_o;
                hold_order = commit_order_o;
            end
            @(negedge clk);
        end
        if (!seen_full) begin
            abort_run("in_ready_o never fell while commit was stalled");
        end
    endtask

    task automatic run_pending(input string name);
        int n;
        n = pend.size();
        fork
            send_pending();
            collect_commits(name, n);
        join
    endtask

    task automatic reset_state_check();
        if (commit_valid_o !== 1'b0) begin
            abort_run("commit_valid_o is not low after reset");
        end
        if (in_ready_o !== 1'b1) begin
            abort_run("in_ready_o is not high after reset");
        end
    endtask

    task automatic alu_op_sweep();
        queue_op(ooo_pkg::alu_add,  5'd1,  32'hffff_ffff, 32'h0000_0001);
        queue_op(ooo_pkg::alu_sub,  5'd2,  32'h0000_0000, 32'h0000_0001);
        queue_op(ooo_pkg::alu_and,  5'd3,  32'hf0f0_1234, 32'h0ff0_ff00);
        queue_op(ooo_pkg::alu_or,   5'd4,  32'h8000_0001, 32'h0000_8000);
        queue_op(ooo_pkg::alu_xor,  5'd5,  32'haaaa_5555, 32'hffff_0000);
        queue_op(ooo_pkg::alu_slt,  5'd6,  32'hffff_fffb, 32'h0000_0003);
        queue_op(ooo_pkg::alu_sltu, 5'd7,  32'hffff_fffb, 32'h0000_0003);
        // shift amounts use only the low five bits
        queue_op(ooo_pkg::alu_sll,  5'd8,  32'h0000_0001, 32'h0000_003f);
        queue_op(ooo_pkg::alu_srl,  5'd9,  32'h8000_0000, 32'h0000_0004);
        queue_op(ooo_pkg::alu_sra,  5'd10, 32'h8000_0000, 32'h0000_0004);
        run_pending("alu_op_sweep");
    endtask

    task automatic random_burst();
        queue_random_ops(60);
        run_pending("random_burst");
    endtask

    task automatic commit_backpressure();
        int n;
        queue_random_ops(30);
        n = pend.size();
        fork
            send_pending();
            begin
                hold_commits("commit_backpressure", HOLD_CYCLES);
                collect_commits("commit_backpressure", n);
            end
        join
    endtask

    task automatic zero_rd_writes();
        repeat (6) begin
            queue_op(ooo_pkg::alu_op_e'(4'(xorshift32() % 10)), 5'd0, xorshift32(), xorshift32());
        end
        run_pending("zero_rd_writes");
    endtask

    initial begin
        repeat (TOTAL_OPS * OP_CYCLES + HOLD_CYCLES + 50) @(posedge clk);
        abort_run("watchdog timeout, commits stopped arriving");
    end

    // a failed dispatch assertion ends the run on the next falling edge
    always @(negedge clk) begin
        if (dut0.dispatch0.asserts0.fail_count != 0) begin
            abort_run("dispatch unit assertion failed");
        end
    end

    initial begin
        rst            = 1'b1;
        in_valid_i     = 1'b0;
        in_op_i        = ooo_pkg::alu_add;
        in_rd_i        = '0;
        in_a_i         = '0;
        in_b_i         = '0;
        commit_ready_i = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_state_check();
        alu_op_sweep();
        random_burst();
        commit_backpressure();
        zero_rd_writes();
        repeat (4) @(negedge clk);
        if (dut0.dispatch0.asserts0.fail_count != 0) begin
            abort_run("dispatch unit assertions failed");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: sim.f
+incdir+include
verilog/ooo_pkg.sv
verilog/lane_if.sv
verilog/op_queue.sv
verilog/dispatch_unit.sv
verilog/alu_lane.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
bench/ooo_core_asserts.sv
bench/ooo_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ooo_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module ooo_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vooo_core_tb +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
    exit 0
fi
exit 1
